/* compile.f */
+incdir+logic
logic/mm_ram_pkg.sv
logic/mm_data_if.sv
logic/dp_ram.sv
logic/mm_timer.sv
logic/mm_decoder.sv
logic/mm_ram.sv
tests/mm_ram_properties.sv
tests/mm_ram_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the mm_ram testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module mm_ram_tb \
    -f compile.f \
    -o mm_ram_sim

output=$(./obj_dir/mm_ram_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

/* tests/mm_ram_tb.sv */
`default_nettype none

`include "mm_ram_settings.svh"

module mm_ram_tb;

    localparam int FILL_WORDS  = 64;
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_FETCH   = 16;
    localparam int TIMER_COUNT = 12;
    // fill, random writes and reads, fetches, then peripheral and timer steps
    localparam int NUM_OPS         = FILL_WORDS + 2 * NUM_RANDOM + NUM_FETCH + 40;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 500;

    typedef struct packed {
        logic        print_valid;
        logic [7:0]  print_data;
        logic        passed;
        logic        failed;
        logic        exit_valid;
        logic [31:0] exit_value;
    } flags_t;

    // one outstanding data response
    typedef struct packed {
        logic        check_data;
        logic        err;
        logic [31:0] data;
    } data_exp_t;

    logic         clk_i;
    logic         rst_ni;
    logic         instr_req_i;
    logic [15:0]  instr_addr_i;
    logic         instr_gnt_o;
    logic         instr_rvalid_o;
    logic [127:0] instr_rdata_o;
    logic         data_req_i;
    logic [31:0]  data_addr_i;
    logic         data_we_i;
    logic [3:0]   data_be_i;
    logic [31:0]  data_wdata_i;
    logic         data_gnt_o;
    logic         data_rvalid_o;
    logic [31:0]  data_rdata_o;
    logic         data_err_o;
    logic         irq_ack_i;
    logic [4:0]   irq_id_i;
    logic         irq_o;
    logic [4:0]   irq_id_o;
    logic         print_valid_o;
    logic [7:0]   print_data_o;
    logic         tests_passed_o;
    logic         tests_failed_o;
    logic         exit_valid_o;
    logic [31:0]  exit_value_o;

    logic [7:0]   shadow [65536];
    logic [31:0]  lcg_state;
    logic [127:0] instr_exp_q [$];
    data_exp_t    data_exp_q [$];
    logic [31:0]  written_q [$];
    logic         instr_req_prev;
    logic         data_req_prev;
    int           value_errors;
    int           other_errors;

    mm_ram uut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_err_o     (data_err_o),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .irq_id_o       (irq_id_o),
        .print_valid_o  (print_valid_o),
        .print_data_o   (print_data_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // error flag and word returned by a data read
    function automatic logic [32:0] expected_read(input logic [31:0] addr);
        logic [31:0] word;
        if (addr[31:16] != 16'h0) begin
            return {1'b1, 32'h0};
        end
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = shadow[{addr[15:2], 2'b00} + 16'(i)];
        end
        return {1'b0, word};
    endfunction

    function automatic logic [127:0] expected_line(input logic [15:0] addr);
        logic [127:0] line;
        for (int i = 0; i < 16; i++) begin
            line[8*i +: 8] = shadow[{addr[15:4], 4'h0} + 16'(i)];
        end
        return line;
    endfunction

    function automatic flags_t expected_flags(input logic we, input logic [31:0] addr,
                                              input logic [31:0] wdata);
        flags_t f;
        f = '0;
        if (we) begin
            f.print_valid = (addr == `MM_PRINT_ADDR);
            f.print_data  = wdata[7:0];
            f.passed      = (addr == `MM_STATUS_ADDR) && (wdata == `MM_PASS_CODE);
            f.failed      = (addr == `MM_STATUS_ADDR) && (wdata == `MM_FAIL_CODE);
            f.exit_valid  = (addr == `MM_EXIT_ADDR);
            f.exit_value  = wdata;
        end
        return f;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // one clock of stimulus on both ports, flags checked mid-cycle
    task automatic bus_cycle(input logic fetch, input logic [15:0] iaddr, input logic access,
                             input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
        flags_t    flags;
        data_exp_t exp;
        @(posedge clk_i);
        instr_req_i  <= fetch;
        instr_addr_i <= iaddr;
        data_req_i   <= access;
        data_addr_i  <= addr;
        data_we_i    <= we;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        // the fetch sees memory as it was before this cycle's write
        if (fetch) begin
            instr_exp_q.push_back(expected_line(iaddr));
        end
        flags = expected_flags(access && we, addr, wdata);
        if (access) begin
            exp.check_data = !we;
            {exp.err, exp.data} = we ? 33'h0 : expected_read(addr);
            data_exp_q.push_back(exp);
        end
        if (access && we && (addr[31:16] == 16'h0)) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    shadow[{addr[15:2], 2'b00} + 16'(i)] = wdata[8*i +: 8];
                end
            end
        end
        @(negedge clk_i);
        check_value("print_valid_o", print_valid_o, flags.print_valid);
        if (flags.print_valid) begin
            check_value("print_data_o", print_data_o, flags.print_data);
        end
        check_value("tests_passed_o", tests_passed_o, flags.passed);
        check_value("tests_failed_o", tests_failed_o, flags.failed);
        check_value("exit_valid_o", exit_valid_o, flags.exit_valid);
        if (flags.exit_valid) begin
            check_value("exit_value_o", exit_value_o, flags.exit_value);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
        bus_cycle(1'b0, 16'h0, 1'b1, 1'b1, addr, wdata, be);
    endtask

    task automatic read_word(input logic [31:0] addr);
        bus_cycle(1'b0, 16'h0, 1'b1, 1'b0, addr, 32'h0, 4'h0);
    endtask

    task automatic bus_idle();
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        data_req_i  <= 1'b0;
        data_we_i   <= 1'b0;
    endtask

    task automatic expect_irq(input logic level, input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_value("irq_o", irq_o, level);
        end
    endtask

    task automatic send_irq_ack(input logic [4:0] id);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        irq_id_i  <= 5'd0;
    endtask

    // load the count, then irq is due in the cycle after load edge + count
    task automatic run_timer(input logic [31:0] mask, input int count);
        write_word(`MM_TIMER_MASK_ADDR, mask, 4'hF);
        write_word(`MM_TIMER_CNT_ADDR, 32'(count), 4'hF);
        bus_idle();
        expect_irq(1'b0, count);
        expect_irq(mask[`MM_TIMER_IRQ_ID], 3);
    endtask

    // responses are matched in order against what was queued at issue
    always @(negedge clk_i) begin : check_responses
        data_exp_t resp;
        if (rst_ni) begin
            check_value("instr_gnt_o", instr_gnt_o, instr_req_i);
            check_value("data_gnt_o", data_gnt_o, data_req_i);
            check_value("instr_rvalid_o", instr_rvalid_o, instr_req_prev);
            check_value("data_rvalid_o", data_rvalid_o, data_req_prev);
            if (instr_rvalid_o) begin
                if (instr_exp_q.size() == 0) begin
                    other_errors++;
                    $display("instruction response at %0t with no fetch outstanding", $time);
                end else begin
                    check_value("instr_rdata_o", instr_rdata_o, instr_exp_q.pop_front());
                end
            end
            if (data_rvalid_o) begin
                if (data_exp_q.size() == 0) begin
                    other_errors++;
                    $display("data response at %0t with no request outstanding", $time);
                end else begin
                    resp = data_exp_q.pop_front();
                    check_value("data_err_o", data_err_o, resp.err);
                    if (resp.check_data) begin
                        check_value("data_rdata_o", data_rdata_o, resp.data);
                    end
                end
            end
        end
        instr_req_prev = instr_req_i;
        data_req_prev  = data_req_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] value;
        lcg_state      = 32'd81;
        value_errors   = 0;
        other_errors   = 0;
        instr_req_prev = 1'b0;
        data_req_prev  = 1'b0;
        rst_ni         = 1'b0;
        instr_req_i    = 1'b0;
        instr_addr_i   = 16'h0;
        data_req_i     = 1'b0;
        data_addr_i    = 32'h0;
        data_we_i      = 1'b0;
        data_be_i      = 4'h0;
        data_wdata_i   = 32'h0;
        irq_ack_i      = 1'b0;
        irq_id_i       = 5'd0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;

        // fill the low 256 bytes, each word mixed with its address
        for (int i = 0; i < FILL_WORDS; i++) begin
            addr = 32'(4 * i);
            write_word(addr, lcg_next() ^ {addr[15:0], addr[15:0]}, 4'hF);
        end

        // random partial writes, then read back back-to-back
        for (int i = 0; i < NUM_RANDOM; i++) begin
            value = lcg_next();
            addr  = {24'h0, value[23:16]};
            written_q.push_back(addr);
            write_word(addr, lcg_next(), value[7:4]);
        end
        foreach (written_q[i]) begin
            read_word(written_q[i]);
        end

        // fetches, every other one beside a write to another line
        for (int i = 0; i < NUM_FETCH; i++) begin
            value = lcg_next();
            if (i % 2 == 0) begin
                bus_cycle(1'b1, {8'h0, value[7:0]}, 1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
            end else begin
                bus_cycle(1'b1, {8'h0, value[7:0]}, 1'b1, 1'b1,
                          {24'h0, value[7:0] ^ 8'h40}, lcg_next(), value[11:8]);
            end
        end
        bus_idle();

        // unmapped accesses
        write_word(32'h3000_0010, 32'hDEAD_BEEF, 4'hF);
        read_word(32'h3000_0010);
        read_word(32'h0000_0010);

        // pseudo-peripherals
        write_word(`MM_PRINT_ADDR, lcg_next(), 4'hF);
        write_word(`MM_STATUS_ADDR, `MM_PASS_CODE, 4'hF);
        write_word(`MM_STATUS_ADDR, `MM_FAIL_CODE, 4'hF);
        write_word(`MM_STATUS_ADDR, 32'h0000_0042, 4'hF);
        write_word(`MM_EXIT_ADDR, lcg_next(), 4'hF);
        bus_idle();

        // timer enabled, wrong id keeps irq, own id clears it
        check_value("irq_id_o", irq_id_o, 5'(`MM_TIMER_IRQ_ID));
        run_timer(lcg_next() | (32'h1 << `MM_TIMER_IRQ_ID), TIMER_COUNT);
        send_irq_ack(5'd5);
        expect_irq(1'b1, 2);
        send_irq_ack(5'(`MM_TIMER_IRQ_ID));
        expect_irq(1'b0, 2);

        // timer masked
        run_timer(lcg_next() & ~(32'h1 << `MM_TIMER_IRQ_ID), TIMER_COUNT);

        repeat (3) @(negedge clk_i);
        if ((instr_exp_q.size() != 0) || (data_exp_q.size() != 0)) begin
            other_errors++;
            $display("%0d instruction and %0d data responses never arrived",
                     instr_exp_q.size(), data_exp_q.size());
        end
        $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
                 value_errors, other_errors, uut.props_i.fail_count);
        if ((value_errors == 0) && (other_errors == 0) && (uut.props_i.fail_count == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/mm_ram_properties.sv */
`default_nettype none

module mm_ram_properties (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic instr_req_i,
    input wire logic instr_gnt_o,
    input wire logic instr_rvalid_o,
    input wire logic data_req_i,
    input wire logic data_gnt_o,
    input wire logic data_rvalid_o,
    input wire logic data_err_o,
    input wire logic tests_passed_o,
    input wire logic tests_failed_o
);

    int unsigned fail_count = 0;

    // no back-pressure on either port
    gnt_equals_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (instr_gnt_o == instr_req_i) && (data_gnt_o == data_req_i))
    else begin
        $error("grant differs from request");
        fail_count++;
    end

    rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (instr_rvalid_o == $past(instr_req_i)) && (data_rvalid_o == $past(data_req_i)))
    else begin
        $error("rvalid does not follow its request by one cycle");
        fail_count++;
    end

    // an error is only reported with a response
    err_needs_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_err_o |-> data_rvalid_o)
    else begin
        $error("data_err_o high without data_rvalid_o");
        fail_count++;
    end

    status_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(tests_passed_o && tests_failed_o))
    else begin
        $error("passed and failed flags high together");
        fail_count++;
    end

endmodule

bind mm_ram mm_ram_properties props_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_err_o     (data_err_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o)
);

`default_nettype wire

/* logic/mm_ram.sv */
`default_nettype none

`include "mm_ram_settings.svh"

module mm_ram (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // instruction fetch
    input  wire logic                    instr_req_i,
    input  wire mm_ram_pkg::ram_addr_t   instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output mm_ram_pkg::instr_line_t      instr_rdata_o,

    // data access
    input  wire logic                    data_req_i,
    input  wire mm_ram_pkg::bus_addr_t   data_addr_i,
    input  wire logic                    data_we_i,
    input  wire mm_ram_pkg::byte_en_t    data_be_i,
    input  wire mm_ram_pkg::word_t       data_wdata_i,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output mm_ram_pkg::word_t            data_rdata_o,
    output logic                         data_err_o,

    // interrupt
    input  wire logic                    irq_ack_i,
    input  wire mm_ram_pkg::irq_id_t     irq_id_i,
    output logic                         irq_o,
    output mm_ram_pkg::irq_id_t          irq_id_o,

    // pseudo-peripherals
    output logic                         print_valid_o,
    output logic [7:0]                   print_data_o,
    output logic                         tests_passed_o,
    output logic                         tests_failed_o,
    output logic                         exit_valid_o,
    output mm_ram_pkg::word_t            exit_value_o
);

    logic              timer_mask_we;
    logic              timer_cnt_we;
    mm_ram_pkg::word_t timer_wdata;

    mm_data_if ram_bus ();

    // every request is accepted at once, answer comes one cycle later
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
        end
    end

    assign irq_id_o = mm_ram_pkg::irq_id_t'(`MM_TIMER_IRQ_ID);

    mm_decoder decoder_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .data_req_i      (data_req_i),
        .data_addr_i     (data_addr_i),
        .data_we_i       (data_we_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .data_rdata_o    (data_rdata_o),
        .data_err_o      (data_err_o),
        .ram             (ram_bus.master),
        .timer_mask_we_o (timer_mask_we),
        .timer_cnt_we_o  (timer_cnt_we),
        .timer_wdata_o   (timer_wdata),
        .print_valid_o   (print_valid_o),
        .print_data_o    (print_data_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o)
    );

    dp_ram dp_ram_i (
        .clk_i         (clk_i),
        .instr_en_i    (instr_req_i),
        .instr_addr_i  (instr_addr_i),
        .instr_rdata_o (instr_rdata_o),
        .data_port     (ram_bus.ram)
    );

    mm_timer timer_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .mask_we_i (timer_mask_we),
        .cnt_we_i  (timer_cnt_we),
        .wdata_i   (timer_wdata),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o)
    );

endmodule

`default_nettype wire

/* logic/mm_decoder.sv */
`default_nettype none

`include "mm_ram_settings.svh"

module mm_decoder (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // data port from the core
    input  wire logic                    data_req_i,
    input  wire mm_ram_pkg::bus_addr_t   data_addr_i,
    input  wire logic                    data_we_i,
    input  wire mm_ram_pkg::byte_en_t    data_be_i,
    input  wire mm_ram_pkg::word_t       data_wdata_i,
    output mm_ram_pkg::word_t            data_rdata_o,
    output logic                         data_err_o,

    // ram word port
    mm_data_if.master                    ram,

    // timer registers
    output logic                         timer_mask_we_o,
    output logic                         timer_cnt_we_o,
    output mm_ram_pkg::word_t            timer_wdata_o,

    // pseudo-peripherals
    output logic                         print_valid_o,
    output logic [7:0]                   print_data_o,
    output logic                         tests_passed_o,
    output logic                         tests_failed_o,
    output logic                         exit_valid_o,
    output mm_ram_pkg::word_t            exit_value_o
);

    logic                   in_ram;
    logic                   wr_req;
    mm_ram_pkg::rdata_sel_e sel_d;
    mm_ram_pkg::rdata_sel_e sel_q;

    // anything below 2**ADDR_WIDTH lands in the ram
    assign in_ram = (data_addr_i[31:`MM_RAM_ADDR_WIDTH] == '0);
    assign wr_req = data_req_i && data_we_i;

    // ram side, address and payload pass straight through
    assign ram.req   = data_req_i && in_ram;
    assign ram.addr  = data_addr_i[`MM_RAM_ADDR_WIDTH-1:0];
    assign ram.we    = data_we_i;
    assign ram.be    = data_be_i;
    assign ram.wdata = data_wdata_i;

    // timer writes are qualified by the strobes
    assign timer_wdata_o = data_wdata_i;

    // register writes and strobes, unknown addresses fall through
    always_comb begin
        timer_mask_we_o = 1'b0;
        timer_cnt_we_o  = 1'b0;
        print_valid_o   = 1'b0;
        print_data_o    = '0;
        tests_passed_o  = 1'b0;
        tests_failed_o  = 1'b0;
        exit_valid_o    = 1'b0;
        exit_value_o    = '0;

        if (wr_req && !in_ram) begin
            case (data_addr_i)
                `MM_PRINT_ADDR: begin
                    print_valid_o = 1'b1;
                    print_data_o  = data_wdata_i[7:0];
                end
                `MM_TIMER_MASK_ADDR: begin
                    timer_mask_we_o = 1'b1;
                end
                `MM_TIMER_CNT_ADDR: begin
                    timer_cnt_we_o = 1'b1;
                end
                `MM_STATUS_ADDR: begin
                    // any other value is neither pass nor fail
                    tests_passed_o = (data_wdata_i == `MM_PASS_CODE);
                    tests_failed_o = (data_wdata_i == `MM_FAIL_CODE);
                end
                `MM_EXIT_ADDR: begin
                    exit_valid_o = 1'b1;
                    exit_value_o = data_wdata_i;
                end
                default: begin
                end
            endcase
        end
    end

    // reads outside the ram get an error response next cycle
    always_comb begin
        sel_d = mm_ram_pkg::SEL_RAM;
        if (data_req_i && !data_we_i && !in_ram) begin
            sel_d = mm_ram_pkg::SEL_ERR;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= mm_ram_pkg::SEL_RAM;
        end else begin
            sel_q <= sel_d;
        end
    end

    // response mux
    always_comb begin
        data_rdata_o = '0;
        data_err_o   = 1'b0;
        case (sel_q)
            mm_ram_pkg::SEL_RAM: begin
                data_rdata_o = ram.rdata;
            end
            mm_ram_pkg::SEL_ERR: begin
                data_err_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mm_timer.sv */
`default_nettype none

`include "mm_ram_settings.svh"

module mm_timer (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    // register writes from the decoder
    input  wire logic                  mask_we_i,
    input  wire logic                  cnt_we_i,
    input  wire mm_ram_pkg::word_t     wdata_i,

    // interrupt handshake with the core
    input  wire logic                  irq_ack_i,
    input  wire mm_ram_pkg::irq_id_t   irq_id_i,
    output logic                       irq_o
);

    mm_ram_pkg::word_t mask_q;
    mm_ram_pkg::word_t cnt_q;
    logic              irq_q;
    logic              ack_match;

    // only an acknowledge of our own id clears the request
    assign ack_match = irq_ack_i &&
                       (irq_id_i == mm_ram_pkg::irq_id_t'(`MM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            if (mask_we_i) begin
                mask_q <= wdata_i;
            end
            if (cnt_we_i) begin
                cnt_q <= wdata_i;
            end

            // register writes hold the countdown for this cycle
            if (!mask_we_i && !cnt_we_i && (cnt_q != '0)) begin
                cnt_q <= cnt_q - 1'b1;
                // fire on the 1 -> 0 step, if enabled
                if ((cnt_q == 32'd1) && mask_q[`MM_TIMER_IRQ_ID]) begin
                    irq_q <= 1'b1;
                end
            end

            if (ack_match) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

/* logic/dp_ram.sv */
`default_nettype none

`include "mm_ram_settings.svh"

module dp_ram (
    input  wire logic                    clk_i,

    // port a, instruction fetch, read only
    input  wire logic                    instr_en_i,
    input  wire mm_ram_pkg::ram_addr_t   instr_addr_i,
    output mm_ram_pkg::instr_line_t      instr_rdata_o,

    // port b, data side
    mm_data_if.ram                       data_port
);

    localparam int NUM_BYTES  = 2 ** `MM_RAM_ADDR_WIDTH;
    localparam int LINE_BYTES = `MM_INSTR_WIDTH / 8;
    localparam int LINE_LSB   = $clog2(LINE_BYTES);

    logic [7:0] mem [NUM_BYTES];

    // fetch line, low address in the low byte
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <=
                    mem[{instr_addr_i[`MM_RAM_ADDR_WIDTH-1:LINE_LSB], i[LINE_LSB-1:0]}];
            end
        end
    end

    // word port, either a read or a byte-masked write per cycle
    always_ff @(posedge clk_i) begin
        if (data_port.req) begin
            if (data_port.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (data_port.be[i]) begin
                        mem[{data_port.addr[`MM_RAM_ADDR_WIDTH-1:2], i[1:0]}] <=
                            data_port.wdata[8*i +: 8];
                    end
                end
            end else begin
                for (int i = 0; i < 4; i++) begin
                    data_port.rdata[8*i +: 8] <=
                        mem[{data_port.addr[`MM_RAM_ADDR_WIDTH-1:2], i[1:0]}];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mm_data_if.sv */
`default_nettype none

// one word-wide ram port, request side and read data
interface mm_data_if;

    logic                  req;
    mm_ram_pkg::ram_addr_t addr;
    logic                  we;
    mm_ram_pkg::byte_en_t  be;
    mm_ram_pkg::word_t     wdata;
    // valid the cycle after req
    mm_ram_pkg::word_t     rdata;

    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  rdata
    );

    modport ram (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* logic/mm_ram_pkg.sv */
`default_nettype none

`include "mm_ram_settings.svh"

package mm_ram_pkg;

    // data side words and addresses
    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [3:0]  byte_en_t;

    // byte address into the dual-port ram
    typedef logic [`MM_RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // one fetch line
    typedef logic [`MM_INSTR_WIDTH-1:0] instr_line_t;

    typedef logic [4:0] irq_id_t;

    // source of the data returned in the response cycle
    typedef enum logic {
        SEL_RAM,
        SEL_ERR
    } rdata_sel_e;

endpackage

`default_nettype wire

/* logic/mm_ram_settings.svh */
`ifndef MM_RAM_SETTINGS_SVH
`define MM_RAM_SETTINGS_SVH

// memory geometry
`define MM_RAM_ADDR_WIDTH 16
`define MM_INSTR_WIDTH 128

// pseudo-peripheral map on the data side
`define MM_PRINT_ADDR 32'h1000_0000
`define MM_TIMER_MASK_ADDR 32'h1500_0000
`define MM_TIMER_CNT_ADDR 32'h1500_0004
`define MM_STATUS_ADDR 32'h2000_0000
`define MM_EXIT_ADDR 32'h2000_0004

// values written to the status register by the test program
`define MM_PASS_CODE 32'd123456789
`define MM_FAIL_CODE 32'd1

// interrupt line used by the countdown timer,
// also the bit that enables it in the mask register
`define MM_TIMER_IRQ_ID 3

`endif
